/* hdl/c2c_pkg.sv */
`default_nettype none

package c2c_pkg;

    //////////////////////////////////////////////////
    // link sizing.
    //////////////////////////////////////////////////

    // number of slave controls hanging off the link.
    localparam int N_SLAVES = 4;
    // width of a slave index in a send command.
    localparam int SLAVE_IDX_W = 2;
    // width of one value carried over the link.
    localparam int DATA_W = 3;

    // hold counter width, wide enough for the hold time.
    localparam int HOLD_CNT_W = 4;
    // cycles a slave shows notice before it acks.
    localparam logic [HOLD_CNT_W-1:0] HOLD_CYCLES = HOLD_CNT_W'(8);

    //////////////////////////////////////////////////
    // seven-segment patterns.
    //////////////////////////////////////////////////

    localparam int SEG_W = 7;

    // active-high segments, msb is a, lsb is g.
    localparam logic [SEG_W-1:0] seg_table [2**DATA_W] = '{
        7'b111_1110,  // 0.
        7'b011_0000,  // 1.
        7'b110_1101,  // 2.
        7'b111_1001,  // 3.
        7'b011_0011,  // 4.
        7'b101_1011,  // 5.
        7'b101_1111,  // 6.
        7'b111_0000   // 7.
    };

    //////////////////////////////////////////////////
    // bundles.
    //////////////////////////////////////////////////

    // shared data bus, master to every slave.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              valid;
    } c2c_bus_t;

    // per-slave status toward the display.
    typedef struct packed {
        logic              notice;
        logic [DATA_W-1:0] data;
    } c2c_slave_out_t;

    // send command at the top port.
    typedef struct packed {
        logic [SLAVE_IDX_W-1:0] target;
        logic [DATA_W-1:0]      value;
    } c2c_cmd_t;

endpackage

`default_nettype wire

/* hdl/c2c_master.sv */
`default_nettype none

module c2c_master (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           send,
    input  c2c_pkg::c2c_cmd_t              cmd,
    input  logic [c2c_pkg::N_SLAVES-1:0]   ack,
    output logic                           busy,
    output logic [c2c_pkg::N_SLAVES-1:0]   request,
    output c2c_pkg::c2c_bus_t              bus
);

    //////////////////////////////////////////////////
    // state and command storage.
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        state_idle,
        state_wait_ack,
        state_send_data
    } state_t;

    state_t state;

    // command captured when a send is taken.
    logic [c2c_pkg::SLAVE_IDX_W-1:0] target_q;
    logic [c2c_pkg::DATA_W-1:0]      value_q;

    // one-hot request pattern for the incoming command.
    logic [c2c_pkg::N_SLAVES-1:0] target_onehot;
    // ack bit of the slave being served.
    logic target_ack;
    // a send strobe that the master takes this cycle.
    logic send_take;

    //////////////////////////////////////////////////
    // decode.
    //////////////////////////////////////////////////

    always_comb begin
        target_onehot = '0;
        target_onehot[cmd.target] = 1'b1;
    end

    // only the addressed slave's ack is watched.
    assign target_ack = ack[target_q];

    // sends outside idle are dropped.
    assign send_take = send && (state == state_idle);

    // busy covers request, ack wait and the valid cycle.
    assign busy = (state != state_idle);

    //////////////////////////////////////////////////
    // sequencer.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= state_idle;
            request <= '0;
            bus     <= '0;
        end else begin
            case (state)
                state_idle: begin
                    bus.valid <= 1'b0;
                    // raise the target's line and hold it.
                    if (send) begin
                        state   <= state_wait_ack;
                        request <= target_onehot;
                    end
                end
                state_wait_ack: begin
                    // ack seen, drop request and put the value out.
                    if (target_ack) begin
                        state     <= state_send_data;
                        request   <= '0;
                        bus.data  <= value_q;
                        bus.valid <= 1'b1;
                    end
                end
                state_send_data: begin
                    // valid lasts exactly one cycle.
                    state     <= state_idle;
                    bus.valid <= 1'b0;
                end
                default: begin
                    state   <= state_idle;
                    request <= '0;
                end
            endcase
        end
    end

    // command latch.
    always_ff @(posedge clk) begin
        if (send_take) begin
            target_q <= cmd.target;
            value_q  <= cmd.value;
        end
    end

endmodule

`default_nettype wire

/* hdl/c2c_slave.sv */
`default_nettype none

module c2c_slave (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    request,
    input  c2c_pkg::c2c_bus_t       bus,
    output logic                    ack,
    output c2c_pkg::c2c_slave_out_t slave_out
);

    //////////////////////////////////////////////////
    // state and registers.
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        state_wait_rqst,
        state_hold,
        state_wait_data
    } state_t;

    state_t state;
    state_t next_state;

    logic next_ack;
    logic notice;
    logic next_notice;

    // last value received, shown on the display.
    logic [c2c_pkg::DATA_W-1:0] data;
    logic [c2c_pkg::DATA_W-1:0] next_data;

    // hold counter, runs only in state_hold.
    logic [c2c_pkg::HOLD_CNT_W-1:0] cnt;
    logic [c2c_pkg::HOLD_CNT_W-1:0] next_cnt;
    logic                           hold_done;

    // last hold cycle, ack goes out on this edge.
    assign hold_done = (cnt == c2c_pkg::HOLD_CYCLES - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= state_wait_rqst;
            ack    <= 1'b0;
            notice <= 1'b0;
            data   <= '0;
            cnt    <= '0;
        end else begin
            state  <= next_state;
            ack    <= next_ack;
            notice <= next_notice;
            data   <= next_data;
            cnt    <= next_cnt;
        end
    end

    //////////////////////////////////////////////////
    // next-state logic.
    //////////////////////////////////////////////////

    always_comb begin
        next_state  = state;
        next_ack    = ack;
        next_notice = notice;
        next_data   = data;
        next_cnt    = cnt;
        case (state)
            state_wait_rqst: begin
                // notice lights as soon as the request is seen.
                next_state  = request ? state_hold : state_wait_rqst;
                next_notice = request;
                next_ack    = 1'b0;
                next_cnt    = '0;
            end
            state_hold: begin
                // keep notice until the hold time is up, then ack.
                next_state  = hold_done ? state_wait_data : state_hold;
                next_notice = !hold_done;
                next_ack    = hold_done;
                next_cnt    = cnt + 1'b1;
            end
            state_wait_data: begin
                // valid only comes after our own ack.
                next_state  = bus.valid ? state_wait_rqst : state_wait_data;
                next_notice = bus.valid;
                next_ack    = !bus.valid;
                next_data   = bus.valid ? bus.data : data;
                next_cnt    = '0;
            end
            default: begin
                next_state = state_wait_rqst;
            end
        endcase
    end

    assign slave_out.notice = notice;
    assign slave_out.data   = data;

endmodule

`default_nettype wire

/* hdl/c2c_display.sv */
`default_nettype none

module c2c_display (
    input  c2c_pkg::c2c_slave_out_t [c2c_pkg::N_SLAVES-1:0] slave_out,
    output logic [c2c_pkg::N_SLAVES-1:0][c2c_pkg::SEG_W-1:0] seg,
    output logic [c2c_pkg::N_SLAVES-1:0]                     notice_led
);

    //////////////////////////////////////////////////
    // digit lookup.
    //////////////////////////////////////////////////

    // table lookup for one digit.
    function automatic logic [c2c_pkg::SEG_W-1:0] digit_pattern(
        input logic [c2c_pkg::DATA_W-1:0] value
    );
        digit_pattern = c2c_pkg::seg_table[value];
    endfunction

    //////////////////////////////////////////////////
    // drain every slave.
    //////////////////////////////////////////////////

    // one digit per slave, purely combinational.
    always_comb begin
        for (int i = 0; i < c2c_pkg::N_SLAVES; i++) begin
            seg[i] = digit_pattern(slave_out[i].data);
        end
    end

    // led i follows slave i's notice line.
    always_comb begin
        for (int i = 0; i < c2c_pkg::N_SLAVES; i++) begin
            notice_led[i] = slave_out[i].notice;
        end
    end

endmodule

`default_nettype wire

/* hdl/c2c_top.sv */
`default_nettype none

module c2c_top (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             send,
    input  c2c_pkg::c2c_cmd_t                                cmd,
    output logic                                             busy,
    output logic [c2c_pkg::N_SLAVES-1:0][c2c_pkg::SEG_W-1:0] seg,
    output logic [c2c_pkg::N_SLAVES-1:0]                     notice_led
);

    //////////////////////////////////////////////////
    // link wiring.
    //////////////////////////////////////////////////

    // one request and one ack line per slave.
    logic [c2c_pkg::N_SLAVES-1:0] request;
    logic [c2c_pkg::N_SLAVES-1:0] ack;

    // shared data bus.
    c2c_pkg::c2c_bus_t bus;

    // per-slave status into the display.
    c2c_pkg::c2c_slave_out_t [c2c_pkg::N_SLAVES-1:0] slave_out;

    c2c_master u_master (
        .clk     (clk),
        .rst_n   (rst_n),
        .send    (send),
        .cmd     (cmd),
        .ack     (ack),
        .busy    (busy),
        .request (request),
        .bus     (bus)
    );

    // identical slaves, each on its own request line.
    for (genvar i = 0; i < c2c_pkg::N_SLAVES; i++) begin : g_slave
        c2c_slave u_slave (
            .clk       (clk),
            .rst_n     (rst_n),
            .request   (request[i]),
            .bus       (bus),
            .ack       (ack[i]),
            .slave_out (slave_out[i])
        );
    end

    c2c_display u_display (
        .slave_out  (slave_out),
        .seg        (seg),
        .notice_led (notice_led)
    );

endmodule

`default_nettype wire

/* sim/c2c_tb.sv */
`default_nettype none

module c2c_tb;

    //////////////////////////////////////////////////
    // dut signals and bookkeeping.
    //////////////////////////////////////////////////

    // one transfer is HOLD_CYCLES plus a few cycles, so this is generous.
    localparam int TIMEOUT_CYCLES = 200;

    logic                                             clk;
    logic                                             rst_n;
    logic                                             send;
    c2c_pkg::c2c_cmd_t                                cmd;
    logic                                             busy;
    logic [c2c_pkg::N_SLAVES-1:0][c2c_pkg::SEG_W-1:0] seg;
    logic [c2c_pkg::N_SLAVES-1:0]                     notice_led;

    // last value delivered to each slave.
    logic [c2c_pkg::DATA_W-1:0] model_value [c2c_pkg::N_SLAVES];

    logic [31:0] lcg_state;
    int          error_count;
    int          timeout_count;

    c2c_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .send       (send),
        .cmd        (cmd),
        .busy       (busy),
        .seg        (seg),
        .notice_led (notice_led)
    );

    // 20 time unit period.
    always #10 clk = ~clk;

    // numerical recipes constants.
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////////////////////////
    // helpers, all start and end on a falling edge.
    //////////////////////////////////////////////////

    task automatic apply_reset();
        rst_n = 1'b0;
        send  = 1'b0;
        cmd   = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
    endtask

    // one-cycle send strobe.
    task automatic issue_send(input logic [c2c_pkg::SLAVE_IDX_W-1:0] target,
                              input logic [c2c_pkg::DATA_W-1:0] value);
        cmd.target = target;
        cmd.value  = value;
        send       = 1'b1;
        @(negedge clk);
        send       = 1'b0;
    endtask

    // wait for busy to fall, watching the notice leds on the way.
    task automatic wait_transfer_end(input logic [c2c_pkg::SLAVE_IDX_W-1:0] target,
                                     output int notice_cycles);
        logic [c2c_pkg::N_SLAVES-1:0] others;
        int                           n;
        others         = '1;
        others[target] = 1'b0;
        notice_cycles  = 0;
        n              = 0;
        while (busy && n < TIMEOUT_CYCLES) begin
            // idle slaves must stay dark.
            assert ((notice_led & others) == '0) else begin
                error_count++;
                $display("[ERROR] %0t: notice on a non-target slave, led=%b target=%0d",
                         $time, notice_led, target);
            end
            if (notice_led[target]) begin
                notice_cycles++;
            end
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeout_count++;
            $display("timeout: busy stayed high for %0d cycles after a send to slave %0d",
                     TIMEOUT_CYCLES, target);
        end
    endtask

    // the notice pulse after the latch ends one cycle later.
    task automatic wait_notice_clear();
        int n;
        n = 0;
        while (notice_led != '0 && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (notice_led != '0) begin
            timeout_count++;
            $display("timeout: notice leds did not clear within %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // every digit against the model.
    task automatic check_all_segs(input string context_name);
        for (int i = 0; i < c2c_pkg::N_SLAVES; i++) begin
            assert (seg[i] == c2c_pkg::seg_table[model_value[i]]) else begin
                error_count++;
                $display("[ERROR] %0t: %s, slave %0d seg=%b expected %b", $time,
                         context_name, i, seg[i], c2c_pkg::seg_table[model_value[i]]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests.
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        assert (!busy) else begin
            error_count++;
            $display("[ERROR] %0t: busy high after reset", $time);
        end
        assert (notice_led == '0) else begin
            error_count++;
            $display("[ERROR] %0t: notice_led=%b after reset", $time, notice_led);
        end
        check_all_segs("reset state");
    endtask

    task automatic test_single_transfer();
        int notice_cycles;
        issue_send(2'd2, 3'd5);
        wait_transfer_end(2'd2, notice_cycles);
        model_value[2] = 3'd5;
        check_all_segs("single transfer");
        wait_notice_clear();
    endtask

    task automatic test_notice();
        int notice_cycles;
        issue_send(2'd1, 3'd6);
        wait_transfer_end(2'd1, notice_cycles);
        // the hold phase alone lights notice for several cycles.
        assert (notice_cycles > 0) else begin
            error_count++;
            $display("[ERROR] %0t: no notice seen during the transfer to slave 1", $time);
        end
        wait_notice_clear();
        model_value[1] = 3'd6;
        check_all_segs("notice");
    endtask

    task automatic test_dropped_send();
        int notice_cycles;
        issue_send(2'd0, 3'd3);
        assert (busy) else begin
            error_count++;
            $display("[ERROR] %0t: busy low right after an accepted send", $time);
        end
        // second command lands while the first is in flight.
        issue_send(2'd3, 3'd4);
        wait_transfer_end(2'd0, notice_cycles);
        model_value[0] = 3'd3;
        check_all_segs("dropped send");
        wait_notice_clear();
        // nothing queued behind the first command.
        assert (!busy) else begin
            error_count++;
            $display("[ERROR] %0t: busy rose again after the dropped send", $time);
        end
        check_all_segs("dropped send, settled");
    endtask

    task automatic test_random_traffic();
        logic [c2c_pkg::SLAVE_IDX_W-1:0] target;
        logic [c2c_pkg::DATA_W-1:0]      value;
        int                              notice_cycles;
        for (int k = 0; k < 40; k++) begin
            lcg_state = lcg_next(lcg_state);
            // upper bits of the lcg are the better ones.
            target = lcg_state[16 +: c2c_pkg::SLAVE_IDX_W];
            value  = lcg_state[24 +: c2c_pkg::DATA_W];
            issue_send(target, value);
            wait_transfer_end(target, notice_cycles);
            model_value[target] = value;
            check_all_segs("random traffic");
        end
    endtask

    //////////////////////////////////////////////////
    // sequence and closing report.
    //////////////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        lcg_state     = 32'h6f2a_9457;
        for (int i = 0; i < c2c_pkg::N_SLAVES; i++) begin
            model_value[i] = '0;
        end
        apply_reset();
        test_reset_state();
        test_single_transfer();
        test_notice();
        test_dropped_send();
        test_random_traffic();
        $display("closing report: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/c2c_pkg.sv
hdl/c2c_master.sv
hdl/c2c_slave.sv
hdl/c2c_display.sv
hdl/c2c_top.sv
sim/c2c_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -f project.f --top-module c2c_tb -o c2c_sim \
    > "$BUILD_LOG" 2>&1 || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/c2c_sim > "$SIM_LOG" 2>&1 || echo "simulator exited with an error"

cat "$SIM_LOG"

grep -q "^TEST PASSED$" "$SIM_LOG" && exit 0 || exit 1
